/* logic/rv64_pkg.sv */
// shared widths and control encodings for the rv64 execute unit, imported by each rtl block
package rv64_pkg;

  localparam int XLEN   = 64;
  localparam int ILEN   = 32;
  localparam int REG_AW = 5;

  // load sizes in bits
  localparam int BYTE_W = 8;
  localparam int HALF_W = 16;
  localparam int WORD_W = 32;

  localparam logic [ILEN-1:0] INSTR_EBREAK = 32'h0010_0073;

  typedef enum logic [4:0] {
    alu_add      = 5'b00000,
    alu_sub      = 5'b00001,
    alu_slt      = 5'b00010,
    alu_sltu     = 5'b00011,
    alu_xor      = 5'b00100,
    alu_and      = 5'b00101,
    alu_or       = 5'b00110,
    alu_sll      = 5'b00111,
    alu_srl      = 5'b01000,
    alu_sra      = 5'b01001,
    alu_mul      = 5'b01010,
    alu_div      = 5'b01011,
    alu_divu     = 5'b01100,
    alu_rem      = 5'b01101,
    alu_remu     = 5'b01110,
    alu_copy_imm = 5'b01111,
    alu_mulh     = 5'b11001,
    alu_mulhsu   = 5'b11010,
    alu_mulhu    = 5'b11011
  } alu_op_e;

  typedef enum logic [6:0] {
    opc_op        = 7'b0110011,
    opc_op_imm    = 7'b0010011,
    opc_op_32     = 7'b0111011,
    opc_op_imm_32 = 7'b0011011,
    opc_lui       = 7'b0110111,
    opc_auipc     = 7'b0010111,
    opc_jal       = 7'b1101111,
    opc_jalr      = 7'b1100111,
    opc_branch    = 7'b1100011,
    opc_load      = 7'b0000011,
    opc_system    = 7'b1110011
  } opcode_e;

  // nine next-pc kinds, so one bit wider than the funct3 field
  typedef enum logic [3:0] {
    brn_none, brn_jal, brn_jalr,
    brn_beq, brn_bne, brn_blt, brn_bge, brn_bltu, brn_bgeu
  } branch_e;

  typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_e;

  typedef enum logic [2:0] {
    ld_lb = 3'b000, ld_lbu = 3'b001, ld_lh = 3'b010, ld_lhu = 3'b011,
    ld_lw = 3'b100, ld_lwu = 3'b101, ld_ld = 3'b110
  } load_op_e;

endpackage

/* logic/rv64_decode.sv */
// instruction decoder, maps one rv64im word to execute, load and writeback controls
`timescale 1ns/100ps

module rv64_decode import rv64_pkg::*; (
  input  logic [ILEN-1:0]   i_instr,
  output alu_op_e           o_alu_op,
  output logic              o_src_a_pc,
  output src_b_e            o_src_b_sel,
  output logic              o_word,
  output branch_e           o_branch,
  output logic [XLEN-1:0]   o_imm,
  output load_op_e          o_load_op,
  output logic              o_mem_to_reg,
  output logic [REG_AW-1:0] o_rd_addr,
  output logic              o_rd_we,
  output logic              o_illegal,
  output logic              o_halt
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_b, imm_u, imm_j;
  alu_op_e         r_op;
  logic            r_ok, word_ok;
  logic            imm_word, sh_zero, sh_arith;
  logic            writes_rd;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_b = {{(XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  // register forms, shared by op and op_32
  always_comb begin
    r_op = alu_add;
    r_ok = 1'b1;
    case (funct7)
      7'b0000000: begin
        case (funct3)
          3'b000:  r_op = alu_add;
          3'b001:  r_op = alu_sll;
          3'b010:  r_op = alu_slt;
          3'b011:  r_op = alu_sltu;
          3'b100:  r_op = alu_xor;
          3'b101:  r_op = alu_srl;
          3'b110:  r_op = alu_or;
          default: r_op = alu_and;
        endcase
      end
      7'b0100000: begin
        r_op = (funct3 == 3'b101) ? alu_sra : alu_sub;
        r_ok = (funct3 == 3'b000) || (funct3 == 3'b101);
      end
      7'b0000001: begin
        case (funct3)
          3'b000:  r_op = alu_mul;
          3'b001:  r_op = alu_mulh;
          3'b010:  r_op = alu_mulhsu;
          3'b011:  r_op = alu_mulhu;
          3'b100:  r_op = alu_div;
          3'b101:  r_op = alu_divu;
          3'b110:  r_op = alu_rem;
          default: r_op = alu_remu;
        endcase
      end
      default: r_ok = 1'b0;
    endcase
  end

  // op_32 only has add, sub, shifts and the word m-ops
  assign word_ok = (funct7 == 7'b0000001) ? (funct3 == 3'b000 || funct3[2])
                 : (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101);

  // rv64 immediate shifts take shamt[5] from bit 25, word shifts do not
  assign imm_word = opcode == opc_op_imm_32;
  assign sh_zero  = imm_word ? funct7 == 7'b0 : i_instr[31:26] == 6'b0;
  assign sh_arith = imm_word ? funct7 == 7'b0100000 : i_instr[31:26] == 6'b010000;

  always_comb begin
    o_alu_op     = alu_add;
    o_src_a_pc   = 1'b0;
    o_src_b_sel  = src_b_rs2;
    o_word       = 1'b0;
    o_branch     = brn_none;
    o_imm        = imm_i;
    o_load_op    = ld_ld;
    o_mem_to_reg = 1'b0;
    writes_rd    = 1'b0;
    o_illegal    = 1'b0;
    o_halt       = 1'b0;
    case (opcode)
      opc_op, opc_op_32: begin
        o_alu_op  = r_op;
        o_word    = opcode == opc_op_32;
        writes_rd = 1'b1;
        o_illegal = !r_ok || (o_word && !word_ok);
      end
      opc_op_imm, opc_op_imm_32: begin
        o_src_b_sel = src_b_imm;
        o_word      = imm_word;
        writes_rd   = 1'b1;
        case (funct3)
          3'b000:  o_alu_op = alu_add;
          3'b001:  o_alu_op = alu_sll;
          3'b010:  o_alu_op = alu_slt;
          3'b011:  o_alu_op = alu_sltu;
          3'b100:  o_alu_op = alu_xor;
          3'b101:  o_alu_op = sh_arith ? alu_sra : alu_srl;
          3'b110:  o_alu_op = alu_or;
          default: o_alu_op = alu_and;
        endcase
        o_illegal = (funct3 == 3'b001 && !sh_zero) ||
                    (funct3 == 3'b101 && !sh_zero && !sh_arith) ||
                    (imm_word && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101);
      end
      opc_lui: begin
        o_alu_op  = alu_copy_imm;
        o_imm     = imm_u;
        writes_rd = 1'b1;
      end
      opc_auipc: begin
        o_src_a_pc  = 1'b1;
        o_src_b_sel = src_b_imm;
        o_imm       = imm_u;
        writes_rd   = 1'b1;
      end
      opc_jal, opc_jalr: begin
        // link value pc+4 comes out of the alu
        o_src_a_pc  = 1'b1;
        o_src_b_sel = src_b_four;
        o_branch    = (opcode == opc_jal) ? brn_jal : brn_jalr;
        o_imm       = (opcode == opc_jal) ? imm_j : imm_i;
        writes_rd   = 1'b1;
        o_illegal   = (opcode == opc_jalr) && (funct3 != 3'b000);
      end
      opc_branch: begin
        o_alu_op = alu_sub;
        o_imm    = imm_b;
        case (funct3)
          3'b000:  o_branch = brn_beq;
          3'b001:  o_branch = brn_bne;
          3'b100:  o_branch = brn_blt;
          3'b101:  o_branch = brn_bge;
          3'b110:  o_branch = brn_bltu;
          3'b111:  o_branch = brn_bgeu;
          default: o_illegal = 1'b1;
        endcase
      end
      opc_load: begin
        o_src_b_sel  = src_b_imm;
        o_mem_to_reg = 1'b1;
        writes_rd    = 1'b1;
        case (funct3)
          3'b000:  o_load_op = ld_lb;
          3'b001:  o_load_op = ld_lh;
          3'b010:  o_load_op = ld_lw;
          3'b011:  o_load_op = ld_ld;
          3'b100:  o_load_op = ld_lbu;
          3'b101:  o_load_op = ld_lhu;
          3'b110:  o_load_op = ld_lwu;
          default: o_illegal = 1'b1;
        endcase
      end
      opc_system: begin
        o_halt    = i_instr == INSTR_EBREAK;
        o_illegal = i_instr != INSTR_EBREAK;
      end
      default: o_illegal = 1'b1;
    endcase
  end

  assign o_rd_addr = i_instr[11:7];
  assign o_rd_we   = writes_rd && !o_illegal && (o_rd_addr != '0);

endmodule

/* logic/rv64_alu.sv */
// combinational execute block, alu result and next pc from decoded controls
`timescale 1ns/100ps

module rv64_alu import rv64_pkg::*; (
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  input  alu_op_e         i_alu_op,
  input  logic            i_src_a_pc,
  input  src_b_e          i_src_b_sel,
  input  logic            i_word,
  input  branch_e         i_branch,
  output logic [XLEN-1:0] o_alu_result,
  output logic [XLEN-1:0] o_next_pc
);

  logic [XLEN-1:0]        b_raw, src_a, src_b;
  logic                   sx_word;
  logic [5:0]             shamt;
  logic [XLEN:0]          diff;
  logic                   eq, lt, ltu, taken;
  logic [2*XLEN-1:0]      prod_ss, prod_su, prod_uu;
  logic                   div_zero, div_ovf;
  logic [XLEN-1:0]        sdiv_den, udiv_den, quot_s, rem_s, quot_u, rem_u;
  logic signed [XLEN-1:0] sdiv_q, sdiv_r;
  logic [XLEN-1:0]        raw, target;

  function automatic logic [XLEN-1:0] cut_word(input logic [XLEN-1:0] v, input logic sx);
    return {{(XLEN-WORD_W){sx & v[WORD_W-1]}}, v[WORD_W-1:0]};
  endfunction

  always_comb begin
    case (i_src_b_sel)
      src_b_imm:  b_raw = i_imm;
      src_b_four: b_raw = XLEN'(4);
      default:    b_raw = i_rs2;
    endcase
  end

  // word operands sign-extended only for the signed word ops
  assign sx_word = i_alu_op inside {alu_sra, alu_div, alu_rem};
  assign src_a   = i_src_a_pc ? i_pc : (i_word ? cut_word(i_rs1, sx_word) : i_rs1);
  assign src_b   = i_word ? cut_word(b_raw, sx_word) : b_raw;
  assign shamt   = i_word ? {1'b0, src_b[4:0]} : src_b[5:0];

  // one subtractor for sub, set-less-than and branch compares
  assign diff = {1'b0, src_a} + {1'b0, ~src_b} + 1'b1;
  assign eq   = diff[XLEN-1:0] == '0;
  assign ltu  = !diff[XLEN];
  assign lt   = (src_a[XLEN-1] != src_b[XLEN-1]) ? src_a[XLEN-1] : diff[XLEN-1];

  assign prod_ss = {{XLEN{src_a[XLEN-1]}}, src_a} * {{XLEN{src_b[XLEN-1]}}, src_b};
  assign prod_su = {{XLEN{src_a[XLEN-1]}}, src_a} * {{XLEN{1'b0}}, src_b};
  assign prod_uu = {{XLEN{1'b0}}, src_a} * {{XLEN{1'b0}}, src_b};

  // divisor forced to 1 on the special cases, results patched below
  assign div_zero = src_b == '0;
  assign div_ovf  = (src_a == {1'b1, {(XLEN-1){1'b0}}}) && (&src_b);
  assign sdiv_den = (div_zero || div_ovf) ? XLEN'(1) : src_b;
  assign udiv_den = div_zero ? XLEN'(1) : src_b;
  assign sdiv_q   = $signed(src_a) / $signed(sdiv_den);
  assign sdiv_r   = $signed(src_a) % $signed(sdiv_den);
  assign quot_s   = div_zero ? '1 : (div_ovf ? src_a : sdiv_q);
  assign rem_s    = div_zero ? src_a : (div_ovf ? '0 : sdiv_r);
  assign quot_u   = div_zero ? '1 : src_a / udiv_den;
  assign rem_u    = div_zero ? src_a : src_a % udiv_den;

  always_comb begin
    case (i_alu_op)
      alu_sub:      raw = diff[XLEN-1:0];
      alu_slt:      raw = XLEN'(lt);
      alu_sltu:     raw = XLEN'(ltu);
      alu_xor:      raw = src_a ^ src_b;
      alu_and:      raw = src_a & src_b;
      alu_or:       raw = src_a | src_b;
      alu_sll:      raw = src_a << shamt;
      alu_srl:      raw = src_a >> shamt;
      alu_sra:      raw = $signed(src_a) >>> shamt;
      alu_mul:      raw = prod_uu[XLEN-1:0];
      alu_mulh:     raw = prod_ss[2*XLEN-1:XLEN];
      alu_mulhsu:   raw = prod_su[2*XLEN-1:XLEN];
      alu_mulhu:    raw = prod_uu[2*XLEN-1:XLEN];
      alu_div:      raw = quot_s;
      alu_divu:     raw = quot_u;
      alu_rem:      raw = rem_s;
      alu_remu:     raw = rem_u;
      alu_copy_imm: raw = i_imm;
      default:      raw = src_a + src_b;
    endcase
  end

  assign o_alu_result = i_word ? cut_word(raw, 1'b1) : raw;

  always_comb begin
    case (i_branch)
      brn_jal, brn_jalr: taken = 1'b1;
      brn_beq:           taken = eq;
      brn_bne:           taken = !eq;
      brn_blt:           taken = lt;
      brn_bge:           taken = !lt;
      brn_bltu:          taken = ltu;
      brn_bgeu:          taken = !ltu;
      default:           taken = 1'b0;
    endcase
  end

  // jalr target drops bit 0
  assign target    = (i_branch == brn_jalr) ? ((i_rs1 + i_imm) & ~XLEN'(1)) : i_pc + i_imm;
  assign o_next_pc = taken ? target : i_pc + XLEN'(4);

endmodule

/* logic/rv64_result.sv */
// writeback stage, extends load data, picks the result and holds it under back-pressure
`timescale 1ns/100ps

module rv64_result import rv64_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_in_valid,
  output logic              o_in_ready,
  input  logic [XLEN-1:0]   i_alu_result,
  input  logic [XLEN-1:0]   i_next_pc,
  input  logic [XLEN-1:0]   i_rdata,
  input  load_op_e          i_load_op,
  input  logic              i_mem_to_reg,
  input  logic [REG_AW-1:0] i_rd_addr,
  input  logic              i_rd_we,
  input  logic              i_illegal,
  input  logic              i_halt,
  input  logic              i_out_ready,
  output logic              o_out_valid,
  output logic [XLEN-1:0]   o_rd_data,
  output logic [REG_AW-1:0] o_rd_addr,
  output logic              o_rd_we,
  output logic [XLEN-1:0]   o_next_pc,
  output logic              o_illegal,
  output logic              o_halt
);

  logic [XLEN-1:0] load_val, wb_val;
  logic            accept;

  always_comb begin
    case (i_load_op)
      ld_lb:   load_val = {{(XLEN-BYTE_W){i_rdata[BYTE_W-1]}}, i_rdata[BYTE_W-1:0]};
      ld_lbu:  load_val = {{(XLEN-BYTE_W){1'b0}}, i_rdata[BYTE_W-1:0]};
      ld_lh:   load_val = {{(XLEN-HALF_W){i_rdata[HALF_W-1]}}, i_rdata[HALF_W-1:0]};
      ld_lhu:  load_val = {{(XLEN-HALF_W){1'b0}}, i_rdata[HALF_W-1:0]};
      ld_lw:   load_val = {{(XLEN-WORD_W){i_rdata[WORD_W-1]}}, i_rdata[WORD_W-1:0]};
      ld_lwu:  load_val = {{(XLEN-WORD_W){1'b0}}, i_rdata[WORD_W-1:0]};
      default: load_val = i_rdata;
    endcase
  end

  assign wb_val = i_mem_to_reg ? load_val : i_alu_result;

  // single slot, refills in the same cycle it drains
  assign o_in_ready = !o_out_valid || i_out_ready;
  assign accept     = i_in_valid && o_in_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_out_valid <= 1'b0;
    end else if (o_in_ready) begin
      o_out_valid <= i_in_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_rd_data <= wb_val;
      o_rd_addr <= i_rd_addr;
      o_rd_we   <= i_rd_we;
      o_next_pc <= i_next_pc;
      o_illegal <= i_illegal;
      o_halt    <= i_halt;
    end
  end

endmodule

/* logic/rv64_exu_top.sv */
// rv64im execute unit top, issue stream in, registered writeback stream out
`timescale 1ns/100ps

module rv64_exu_top import rv64_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_in_valid,
  output logic              o_in_ready,
  input  logic [ILEN-1:0]   i_instr,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [XLEN-1:0]   i_rs1,
  input  logic [XLEN-1:0]   i_rs2,
  input  logic [XLEN-1:0]   i_rdata,
  output logic              o_out_valid,
  input  logic              i_out_ready,
  output logic [XLEN-1:0]   o_rd_data,
  output logic [REG_AW-1:0] o_rd_addr,
  output logic              o_rd_we,
  output logic [XLEN-1:0]   o_next_pc,
  output logic              o_illegal,
  output logic              o_halt
);

  alu_op_e           alu_op;
  src_b_e            src_b_sel;
  branch_e           branch;
  load_op_e          load_op;
  logic              src_a_pc, word, mem_to_reg, rd_we, illegal, halt;
  logic [XLEN-1:0]   imm, alu_result, next_pc;
  logic [REG_AW-1:0] rd_addr;

  rv64_decode u_decode (
    .i_instr      (i_instr),
    .o_alu_op     (alu_op),
    .o_src_a_pc   (src_a_pc),
    .o_src_b_sel  (src_b_sel),
    .o_word       (word),
    .o_branch     (branch),
    .o_imm        (imm),
    .o_load_op    (load_op),
    .o_mem_to_reg (mem_to_reg),
    .o_rd_addr    (rd_addr),
    .o_rd_we      (rd_we),
    .o_illegal    (illegal),
    .o_halt       (halt)
  );

  rv64_alu u_alu (
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_pc         (i_pc),
    .i_imm        (imm),
    .i_alu_op     (alu_op),
    .i_src_a_pc   (src_a_pc),
    .i_src_b_sel  (src_b_sel),
    .i_word       (word),
    .i_branch     (branch),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc)
  );

  rv64_result u_result (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_in_valid   (i_in_valid),
    .o_in_ready   (o_in_ready),
    .i_alu_result (alu_result),
    .i_next_pc    (next_pc),
    .i_rdata      (i_rdata),
    .i_load_op    (load_op),
    .i_mem_to_reg (mem_to_reg),
    .i_rd_addr    (rd_addr),
    .i_rd_we      (rd_we),
    .i_illegal    (illegal),
    .i_halt       (halt),
    .i_out_ready  (i_out_ready),
    .o_out_valid  (o_out_valid),
    .o_rd_data    (o_rd_data),
    .o_rd_addr    (o_rd_addr),
    .o_rd_we      (o_rd_we),
    .o_next_pc    (o_next_pc),
    .o_illegal    (o_illegal),
    .o_halt       (o_halt)
  );

endmodule

/* test/rv64_exu_sva.sv */
// stream protocol and reset checks, bound into the writeback stage
`timescale 1ns/100ps

module rv64_exu_sva import rv64_pkg::*; (
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_in_valid,
  input logic              o_in_ready,
  input logic              i_out_ready,
  input logic              o_out_valid,
  input logic [XLEN-1:0]   o_rd_data,
  input logic [REG_AW-1:0] o_rd_addr,
  input logic              o_rd_we,
  input logic [XLEN-1:0]   o_next_pc,
  input logic              o_illegal,
  input logic              o_halt
);

  // reset is synchronous, so valid is clear one edge later
  assert property (@(posedge i_clk) !i_rst_n |=> !o_out_valid)
    else $error("out valid high after reset");

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_rd_data) &&
      $stable(o_rd_addr) && $stable(o_rd_we) && $stable(o_next_pc) &&
      $stable(o_illegal) && $stable(o_halt))
    else $error("writeback changed while stalled");

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_in_valid && o_in_ready |=> o_out_valid)
    else $error("accepted input not presented on next edge");

endmodule

bind rv64_result rv64_exu_sva sva_inst (.*);

/* test/tb_rv64_exu.sv */
// rv64im execute unit testbench, issues directed and random instructions and checks writeback
`timescale 1ns/100ps

module tb_rv64_exu;
  import rv64_pkg::*;

  localparam int ROUNDS    = 6;
  localparam int BURST     = 40;
  localparam int N_PLANNED = ROUNDS * (18 + 10 + 8) + 16 + 4 * 8 + 4 * 7 + 4 + BURST;
  localparam int LIMIT     = 2 * N_PLANNED + 200;

  logic            clk, rst_n, in_valid, out_ready, in_ready, out_valid;
  logic [31:0]     instr;
  logic [XLEN-1:0] pc, rs1, rs2, rdata, rd_data, next_pc;
  logic [4:0]      rd_addr;
  logic            rd_we, illegal, halt;
  bit              stall_mode;
  int              errors, issued, checked, cycles;

  // expected writeback fields per accepted instruction
  string       q_name[$];
  logic [63:0] q_data[$], q_pc[$];
  logic [4:0]  q_rd[$];
  logic        q_we[$], q_ill[$], q_halt[$];

  logic [9:0] r_ops [0:17] = '{10'h000, 10'h001, 10'h002, 10'h003, 10'h004, 10'h005,
                               10'h006, 10'h007, 10'h100, 10'h105, 10'h008, 10'h009,
                               10'h00a, 10'h00b, 10'h00c, 10'h00d, 10'h00e, 10'h00f};
  logic [9:0] w_ops [0:9]  = '{10'h000, 10'h001, 10'h005, 10'h100, 10'h105,
                               10'h008, 10'h00c, 10'h00d, 10'h00e, 10'h00f};

  rv64_exu_top rv64_exu_top_inst (
    .i_clk(clk), .i_rst_n(rst_n), .i_in_valid(in_valid), .o_in_ready(in_ready),
    .i_instr(instr), .i_pc(pc), .i_rs1(rs1), .i_rs2(rs2), .i_rdata(rdata),
    .o_out_valid(out_valid), .i_out_ready(out_ready), .o_rd_data(rd_data),
    .o_rd_addr(rd_addr), .o_rd_we(rd_we), .o_next_pc(next_pc),
    .o_illegal(illegal), .o_halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // riscv division rules with divide by zero and signed overflow
  function automatic logic [63:0] div_ref(input logic [63:0] a, input logic [63:0] b,
                                          input bit w, input bit sgn, input bit rem);
    logic [63:0] x, y, min_v;
    x     = w ? (sgn ? sext32(a) : {32'b0, a[31:0]}) : a;
    y     = w ? (sgn ? sext32(b) : {32'b0, b[31:0]}) : b;
    min_v = w ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
    if (y == '0)
      return rem ? x : '1;
    if (sgn && x == min_v && y == '1)
      return rem ? '0 : x;
    if (sgn)
      return rem ? $signed(x) % $signed(y) : $signed(x) / $signed(y);
    return rem ? x % y : x / y;
  endfunction

  function automatic logic [63:0] ref_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input bit w, input logic [63:0] a,
                                         input logic [63:0] b);
    logic [63:0]  r;
    logic [127:0] p;
    int           sh;
    sh = w ? int'(b[4:0]) : int'(b[5:0]);
    r  = '0;
    case ({f7[5], f7[0], f3})
      5'b00_000: r = a + b;
      5'b10_000: r = a - b;
      5'b00_001: r = a << sh;
      5'b00_010: r = 64'($signed(a) < $signed(b));
      5'b00_011: r = 64'(a < b);
      5'b00_100: r = a ^ b;
      5'b00_101: r = w ? {32'b0, a[31:0]} >> sh : a >> sh;
      5'b10_101: r = w ? $signed(sext32(a)) >>> sh : $signed(a) >>> sh;
      5'b00_110: r = a | b;
      5'b00_111: r = a & b;
      5'b01_000: r = a * b;
      5'b01_001: begin
        p = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
        r = p[127:64];
      end
      5'b01_010: begin
        p = {{64{a[63]}}, a} * {64'b0, b};
        r = p[127:64];
      end
      5'b01_011: begin
        p = {64'b0, a} * {64'b0, b};
        r = p[127:64];
      end
      5'b01_100: r = div_ref(a, b, w, 1'b1, 1'b0);
      5'b01_101: r = div_ref(a, b, w, 1'b0, 1'b0);
      5'b01_110: r = div_ref(a, b, w, 1'b1, 1'b1);
      5'b01_111: r = div_ref(a, b, w, 1'b0, 1'b1);
      default:   r = '0;
    endcase
    return w ? sext32(r) : r;
  endfunction

  // push the expected fields, then hold valid until the dut takes the instruction
  task automatic issue(input string name, input logic [31:0] ins, input logic [63:0] p,
                       input logic [63:0] a, input logic [63:0] b, input logic [63:0] ld,
                       input logic [63:0] e_data, input logic e_we, input logic [63:0] e_pc,
                       input logic e_ill, input logic e_halt);
    bit acc;
    q_name.push_back(name);
    q_data.push_back(e_data);
    q_rd.push_back(ins[11:7]);
    q_we.push_back(e_we);
    q_pc.push_back(e_pc);
    q_ill.push_back(e_ill);
    q_halt.push_back(e_halt);
    issued++;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      out_ready = stall_mode ? 1'($urandom % 2) : 1'b1;
      in_valid  = 1'b1;
      instr     = ins;
      pc        = p;
      rs1       = a;
      rs2       = b;
      rdata     = ld;
      #1;
      acc = in_ready;
      @(posedge clk);
    end
  endtask

  task automatic check(input string name, input string field, input logic [63:0] exp_v,
                       input logic [63:0] act_v);
    assert (exp_v === act_v)
    else begin
      $display("ERR %s %s expected %h actual %h", name, field, exp_v, act_v);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (q_name.size() == 0) begin
        $display("writeback seen with no instruction outstanding");
        errors++;
      end else begin
        check(q_name[0], "next_pc", q_pc.pop_front(), next_pc);
        check(q_name[0], "illegal", 64'(q_ill.pop_front()), 64'(illegal));
        check(q_name[0], "halt", 64'(q_halt.pop_front()), 64'(halt));
        check(q_name[0], "rd_we", 64'(q_we[0]), 64'(rd_we));
        if (q_we[0]) begin
          check(q_name[0], "rd_data", q_data[0], rd_data);
          check(q_name[0], "rd_addr", 64'(q_rd[0]), 64'(rd_addr));
        end
        void'(q_we.pop_front());
        void'(q_data.pop_front());
        void'(q_rd.pop_front());
        void'(q_name.pop_front());
        checked++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    logic [63:0] a, b, p, d, imm;
    logic [11:0] i12;
    logic [12:0] b13;
    logic [20:0] j21;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    bit          w, tk;
    void'($urandom(31));
    {in_valid, out_ready, stall_mode} = '0;
    {instr, pc, rs1, rs2, rdata} = '0;
    {errors, issued, checked, cycles} = '0;
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < ROUNDS; r++) begin
      for (int k = 0; k < 28; k++) begin
        w  = k >= 18;
        {f7, f3} = w ? w_ops[k-18] : r_ops[k];
        a  = rand64();
        b  = rand64();
        p  = rand64() & ~64'h3;
        rd = 5'd1 + 5'($urandom % 31);
        issue(w ? "rop_word" : "rop", {f7, 5'd2, 5'd1, f3, rd, w ? 7'h3b : 7'h33},
              p, a, b, '0, ref_op(f7, f3, w, a, b), 1'b1, p + 4, 1'b0, 1'b0);
      end
      for (int k = 0; k < 8; k++) begin
        w   = k >= 6;
        i12 = 12'($urandom);
        f7  = 7'b0;
        case (k)
          0, 6: f3 = 3'd0;
          1: f3 = 3'd3;
          2: f3 = 3'd4;
          3: f3 = 3'd7;
          4: begin
            f3  = 3'd1;
            i12 = {6'b0, i12[5:0]};
          end
          default: begin
            f3  = 3'd5;
            f7  = 7'b0100000;
            i12 = w ? {7'b0100000, i12[4:0]} : {6'b010000, i12[5:0]};
          end
        endcase
        a   = rand64();
        p   = rand64() & ~64'h3;
        imm = {{52{i12[11]}}, i12};
        issue(w ? "iop_word" : "iop", {i12, 5'd1, f3, 5'd3, w ? 7'h1b : 7'h13},
              p, a, '0, '0, ref_op(f7, f3, w, a, imm), 1'b1, p + 4, 1'b0, 1'b0);
      end
    end

    // divide by zero, then most negative over minus one
    for (int k = 0; k < 16; k++) begin
      w  = k[3];
      f3 = 3'd4 + 3'(k % 4);
      a  = k[2] ? 64'h8000_0000_0000_0000 : rand64();
      if (w && k[2])
        a = 64'h1234_5678_8000_0000;
      b = k[2] ? '1 : '0;
      issue("div_special", {7'h01, 5'd2, 5'd1, f3, 5'd4, w ? 7'h3b : 7'h33}, 64'h100,
            a, b, '0, ref_op(7'h01, f3, w, a, b), 1'b1, 64'h104, 1'b0, 1'b0);
    end

    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 6; k++) begin
        f3  = (k < 2) ? 3'(k) : 3'(k + 2);
        a   = rand64();
        b   = r[0] ? a : rand64();
        if (r == 3)
          b = ~a;
        b13 = {13'($urandom)} & ~13'h1;
        p   = rand64() & ~64'h3;
        case (f3)
          3'd0: tk = a == b;
          3'd1: tk = a != b;
          3'd4: tk = $signed(a) < $signed(b);
          3'd5: tk = $signed(a) >= $signed(b);
          3'd6: tk = a < b;
          default: tk = a >= b;
        endcase
        d = tk ? p + {{51{b13[12]}}, b13} : p + 4;
        issue("branch", {b13[12], b13[10:5], 5'd2, 5'd1, f3, b13[4:1], b13[11], 7'h63},
              p, a, b, '0, '0, 1'b0, d, 1'b0, 1'b0);
      end
      j21 = 21'($urandom) & ~21'h1;
      p   = rand64() & ~64'h3;
      issue("jal", {j21[20], j21[10:1], j21[11], j21[19:12], 5'd1, 7'h6f}, p, '0, '0, '0,
            p + 4, 1'b1, p + {{43{j21[20]}}, j21}, 1'b0, 1'b0);
      i12 = 12'($urandom);
      a   = rand64();
      issue("jalr", {i12, 5'd1, 3'd0, 5'd5, 7'h67}, p, a, '0, '0, p + 4, 1'b1,
            (a + {{52{i12[11]}}, i12}) & ~64'h1, 1'b0, 1'b0);
    end

    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 7; k++) begin
        d = rand64();
        case (k)
          0: imm = {{56{d[7]}}, d[7:0]};
          1: imm = {{48{d[15]}}, d[15:0]};
          2: imm = sext32(d);
          3: imm = d;
          4: imm = {56'b0, d[7:0]};
          5: imm = {48'b0, d[15:0]};
          default: imm = {32'b0, d[31:0]};
        endcase
        issue("load", {12'h010, 5'd1, 3'(k), 5'd6, 7'h03}, 64'h200, rand64(), '0, d,
              imm, 1'b1, 64'h204, 1'b0, 1'b0);
      end
    end

    issue("illegal", 32'hffff_ffff, 64'h300, '0, '0, '0, '0, 1'b0, 64'h304, 1'b1, 1'b0);
    // register form with a bad funct7 and a nonzero rd
    issue("illegal_op", {7'h7f, 5'd2, 5'd1, 3'd0, 5'd7, 7'h33}, 64'h340, '0, '0, '0,
          '0, 1'b0, 64'h344, 1'b1, 1'b0);
    issue("ebreak", 32'h0010_0073, 64'h400, '0, '0, '0, '0, 1'b0, 64'h404, 1'b0, 1'b1);
    issue("rd_x0", {7'h00, 5'd2, 5'd1, 3'd0, 5'd0, 7'h33}, 64'h500, 64'd7, 64'd9, '0,
          '0, 1'b0, 64'h504, 1'b0, 1'b0);

    // back-pressure burst with order and count checked through the queue
    stall_mode = 1'b1;
    for (int k = 0; k < BURST; k++) begin
      a  = rand64();
      b  = rand64();
      rd = 5'd1 + 5'(k % 31);
      f3 = k[0] ? 3'd4 : 3'd0;
      issue("burst", {7'h00, 5'd2, 5'd1, f3, rd, 7'h33}, 64'h1000 + 64'(4 * k), a, b, '0,
            ref_op(7'h00, f3, 1'b0, a, b), 1'b1, 64'h1004 + 64'(4 * k), 1'b0, 1'b0);
    end
    @(negedge clk);
    stall_mode = 1'b0;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    while (q_name.size() > 0)
      @(posedge clk);
    @(negedge clk);
    if (out_valid) begin
      $display("writeback still valid after every issued result was checked");
      errors++;
    end
    $display("errors %0d, issued %0d, checked %0d", errors, issued, checked);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* vlog.f */
logic/rv64_pkg.sv
logic/rv64_decode.sv
logic/rv64_alu.sv
logic/rv64_result.sv
logic/rv64_exu_top.sv
test/rv64_exu_sva.sv
test/tb_rv64_exu.sv

/* Makefile */
SRCS := $(wildcard logic/*.sv test/*.sv)

obj_dir/Vtb_rv64_exu: $(SRCS) vlog.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv64_exu -f vlog.f

run: obj_dir/Vtb_rv64_exu
	obj_dir/Vtb_rv64_exu | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
